// ==== mipsCore.f ====
mipsPkg.sv
datapathCtrlIf.sv
alu.sv
registerFile.sv
datapath.sv
controlUnit.sv
mipsCore.sv
mipsCore_properties.sv
mipsCore_tb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# builds the core with its testbench under Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mipsCore_tb \
    -f mipsCore.f -o simMipsCore
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simMipsCore > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== mipsCore_testdata.txt ====
# M byteAddress word : program image / S byteAddress data : expected store in order
# E epc cause : expected exception in order, all values hex
M 000 20010005
M 004 2002FFFD
M 008 00221820
M 00C AC030200
M 010 00222022
M 014 AC040204
M 018 00222824
M 01C AC050208
M 020 00223026
M 024 AC06020C
M 028 00023900
M 02C AC070210
M 030 00024102
M 034 AC080214
M 038 00024843
M 03C AC090218
M 040 304A00F0
M 044 AC0A021C
M 048 284B0001
M 04C AC0B0220
M 050 282CFFFC
M 054 AC0C0224
M 058 382DFFFF
M 05C AC0D0228
M 060 3C0E8001
M 064 AC0E022C
M 068 25CF7FFF
M 06C AC0F0230
M 070 8C100218
M 074 AC100234
M 078 10220001
M 07C AC010238
M 080 10210001
M 084 AC02023C
M 088 14220001
M 08C AC02023C
M 090 14210001
M 094 AC03023C
M 098 08000029
M 09C AC020240
M 0A0 AC020240
M 0A4 20170002
M 0A8 3C117FFF
M 0AC 02314820
M 0B0 AC090244
M 0B4 FC000000
M 100 26940001
M 104 AC1403F0
M 108 12970001
M 10C 0800002C
M 110 0000000D
S 200 00000002
S 204 00000008
S 208 00000005
S 20C FFFFFFF8
S 210 FFFFFFD0
S 214 0FFFFFFF
S 218 FFFFFFFE
S 21C 000000F0
S 220 00000001
S 224 00000000
S 228 0000FFFA
S 22C 80010000
S 230 80017FFF
S 234 FFFFFFFE
S 238 00000005
S 23C 00000002
S 3F0 00000001
S 244 FFFFFFFE
S 3F0 00000002
E 0AC 1
E 0B4 0

// ==== mipsCore_tb.sv ====
`timescale 1ns/1ps

module mipsCore_tb;
    import mipsPkg::*;

    localparam int MemWords = 1024;

    logic clock;
    logic reset;
    logic [31:0] memReadData;
    logic [31:0] memAddress;
    logic [31:0] memWriteData;
    logic memWrite;
    logic halted;
    logic exceptionTaken;
    logic [31:0] epc;
    excCauseT cause;

    logic [31:0] mem [MemWords];
    logic [9:0] readIndex;
    logic [31:0] storeAddrQ [$];
    logic [31:0] storeDataQ [$];
    logic [31:0] excEpcQ [$];
    logic excCauseQ [$];
    logic excPending;
    int limitCycles;
    int memRecords;

    mipsCore #(
        .HandlerAddress(32'h0000_0100)
    ) dut (
        .clock(clock),
        .reset(reset),
        .memReadData(memReadData),
        .memAddress(memAddress),
        .memWriteData(memWriteData),
        .memWrite(memWrite),
        .halted(halted),
        .exceptionTaken(exceptionTaken),
        .epc(epc),
        .cause(cause)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic failRun();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
            failRun();
        end
    endtask

    task automatic loadTestData();
        int fd;
        int count;
        string line;
        logic [7:0] kind;
        logic [31:0] first;
        logic [31:0] second;
        fd = $fopen("mipsCore_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open mipsCore_testdata.txt");
            failRun();
        end
        for (int i = 0; i < MemWords; i++)
            mem[i] = 32'hA500_0000 | i; // invalid opcode if ever run
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.getc(0) == "#")
                count = 0; // column notes
            else
                count = $sscanf(line, "%c %h %h", kind, first, second);
            if (count == 3) begin
                case (kind)
                    "M": begin
                        mem[first[11:2]] = second;
                        memRecords++;
                    end
                    "S": begin
                        storeAddrQ.push_back(first);
                        storeDataQ.push_back(second);
                    end
                    "E": begin
                        excEpcQ.push_back(first);
                        excCauseQ.push_back(second[0]);
                    end
                    default: begin
                        $display("unknown record kind in test data: %s", line);
                        failRun();
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    // memory model, store checker and exception checker
    always @(negedge clock) begin : monitor
        logic [31:0] expAddr;
        logic [31:0] expData;
        logic [31:0] expEpc;
        logic expCause;
        memReadData <= mem[readIndex]; // one cycle read latency
        readIndex <= memAddress[11:2];
        if (!reset && memWrite) begin
            if (storeAddrQ.size() == 0) begin
                $display("store to %h with no store left to expect", memAddress);
                failRun();
            end
            expAddr = storeAddrQ.pop_front();
            expData = storeDataQ.pop_front();
            check("memAddress", memAddress, expAddr);
            check("memWriteData", memWriteData, expData);
            mem[memAddress[11:2]] = memWriteData;
        end
        if (excPending) begin // epc and cause settle one cycle after the pulse
            if (excEpcQ.size() == 0) begin
                $display("exception at %h that was not expected", epc);
                failRun();
            end
            expEpc = excEpcQ.pop_front();
            expCause = excCauseQ.pop_front();
            check("epc", epc, expEpc);
            check("cause", {31'b0, cause}, {31'b0, expCause});
        end
        excPending <= !reset && exceptionTaken;
    end

    initial begin
        wait (limitCycles != 0);
        repeat (limitCycles) @(posedge clock);
        $display("watchdog expired after %0d cycles without a halt", limitCycles);
        failRun();
    end

    initial begin
        reset = 1'b1;
        memReadData <= '0;
        readIndex <= '0;
        excPending <= 1'b0;
        memRecords = 0;
        limitCycles = 0;
        loadTestData();
        limitCycles = memRecords * 60 + 200;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        while (!halted)
            @(negedge clock);
        repeat (4) @(negedge clock); // catch any late store
        if (storeAddrQ.size() == 0 && excEpcQ.size() == 0 && !excPending) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("halted with %0d stores and %0d exceptions still expected",
                     storeAddrQ.size(), excEpcQ.size());
            failRun();
        end
    end

endmodule

// ==== mipsCore_properties.sv ====
`timescale 1ns/1ps

module mipsCore_properties (
    input logic clock,
    input logic reset,
    input logic memWrite,
    input logic halted,
    input logic exceptionTaken,
    input logic [31:0] memAddress
);

    noStoreWhenHalted: assert property (
        @(posedge clock) disable iff (reset) !(memWrite && halted)
    ) else $error("store issued while halted");

    exceptionPulse: assert property (
        @(posedge clock) disable iff (reset) exceptionTaken |=> !exceptionTaken
    ) else $error("exceptionTaken longer than one cycle");

    haltSticky: assert property (
        @(posedge clock) disable iff (reset) halted |=> halted
    ) else $error("halted dropped without reset");

    // word stores only
    storeAligned: assert property (
        @(posedge clock) disable iff (reset) memWrite |-> (memAddress[1:0] == 2'b00)
    ) else $error("unaligned store address");

endmodule

bind mipsCore mipsCore_properties props (
    .clock(clock),
    .reset(reset),
    .memWrite(memWrite),
    .halted(halted),
    .exceptionTaken(exceptionTaken),
    .memAddress(memAddress)
);

// ==== mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore #(
    parameter logic [mipsPkg::DataWidth-1:0] HandlerAddress = 32'h0000_0100
) (
    input logic clock,
    input logic reset,
    input logic [mipsPkg::DataWidth-1:0] memReadData,
    output logic [mipsPkg::DataWidth-1:0] memAddress,
    output logic [mipsPkg::DataWidth-1:0] memWriteData,
    output logic memWrite,
    output logic halted,
    output logic exceptionTaken,
    output logic [mipsPkg::DataWidth-1:0] epc,
    output mipsPkg::excCauseT cause
);

    datapathCtrlIf ctrlBus ();

    controlUnit control (
        .clock(clock),
        .reset(reset),
        .ctrl(ctrlBus.control),
        .memWrite(memWrite),
        .halted(halted),
        .exceptionTaken(exceptionTaken)
    );

    datapath #(
        .HandlerAddress(HandlerAddress)
    ) dp (
        .clock(clock),
        .reset(reset),
        .ctrl(ctrlBus.datapath),
        .memReadData(memReadData),
        .memAddress(memAddress),
        .memWriteData(memWriteData),
        .epc(epc),
        .cause(cause)
    );

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input logic clock,
    input logic reset,
    datapathCtrlIf.control ctrl,
    output logic memWrite,
    output logic halted,
    output logic exceptionTaken
);
    import mipsPkg::*;

    typedef enum logic [4:0] {
        Fetch, FetchWait, Decode,
        RCalc, RWrite, ICalc, IWrite, LuiWrite,
        MemAddr, LoadRead, LoadWait, LoadWrite, StoreWrite,
        BranchEval, JumpExec, ExcSave, ExcJump, Halted
    } stateT;

    stateT state;
    stateT nextState;
    excCauseT pendingCode; // held from detection until ExcSave
    excCauseT nextCode;
    opcodeT opcode;
    functT funct;

    assign opcode = ctrl.instr.rType.opcode;
    assign funct = ctrl.instr.rType.funct;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= Fetch;
            pendingCode <= ExcInvalidOpcode;
        end else begin
            state <= nextState;
            pendingCode <= nextCode;
        end
    end

    assign ctrl.excCode = pendingCode;
    assign halted = (state == Halted);
    assign exceptionTaken = (state == ExcSave);

    // operand and source selects, independent of the ALU flags
    always_comb begin
        ctrl.aluSrcA = SrcAReg; // memory address from ALUOut
        ctrl.aluSrcB = SrcBReg;
        ctrl.aluOp = AluPassB;
        ctrl.pcSource = PcAluResult;
        ctrl.regSource = RegAluOut;
        ctrl.regDstRd = 1'b0;
        case (state)
            Fetch: ctrl.aluSrcA = SrcAPc;
            FetchWait: begin
                ctrl.aluSrcA = SrcAPc;
                ctrl.aluSrcB = SrcBFour;
                ctrl.aluOp = AluAdd;
            end
            Decode: begin
                ctrl.aluSrcA = SrcAPc;
                if (opcode == OpLui) begin // upper immediate instead of branch target
                    ctrl.aluSrcB = SrcBImm;
                    ctrl.aluOp = AluLui;
                end else begin
                    ctrl.aluSrcB = SrcBBranch;
                    ctrl.aluOp = AluAdd;
                end
            end
            RCalc: begin
                case (funct)
                    FnAdd, FnAddu: ctrl.aluOp = AluAdd;
                    FnSub, FnSubu: ctrl.aluOp = AluSub;
                    FnAnd: ctrl.aluOp = AluAnd;
                    FnXor: ctrl.aluOp = AluXor;
                    FnSll: ctrl.aluOp = AluSll;
                    FnSrl: ctrl.aluOp = AluSrl;
                    FnSra: ctrl.aluOp = AluSra;
                    default: ctrl.aluOp = AluPassB;
                endcase
            end
            RWrite: ctrl.regDstRd = 1'b1;
            ICalc: begin
                ctrl.aluSrcB = SrcBImm;
                case (opcode)
                    OpAddi, OpAddiu: ctrl.aluOp = AluAdd;
                    OpSlti: ctrl.aluOp = AluSlt;
                    OpAndi: ctrl.aluOp = AluAnd;
                    OpXori: ctrl.aluOp = AluXor;
                    default: ctrl.aluOp = AluPassB;
                endcase
            end
            MemAddr: begin
                ctrl.aluSrcB = SrcBImm;
                ctrl.aluOp = AluAdd;
            end
            LoadWrite: ctrl.regSource = RegMdr;
            BranchEval: begin
                ctrl.aluOp = AluSub;
                ctrl.pcSource = PcAluOut; // target computed in Decode
            end
            JumpExec: ctrl.pcSource = PcJump;
            ExcJump: ctrl.pcSource = PcHandler;
            default: ctrl.aluSrcA = SrcAReg;
        endcase
    end

    // enables and next state
    always_comb begin
        nextState = Fetch;
        nextCode = pendingCode;
        memWrite = 1'b0;
        ctrl.pcWrite = 1'b0;
        ctrl.irWrite = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.abWrite = 1'b0;
        ctrl.aluOutWrite = 1'b0;
        ctrl.mdrWrite = 1'b0;
        ctrl.epcWrite = 1'b0;
        ctrl.causeWrite = 1'b0;
        case (state)
            Fetch: nextState = FetchWait;
            FetchWait: begin
                ctrl.irWrite = 1'b1;
                ctrl.pcWrite = 1'b1; // pc + 4
                nextState = Decode;
            end
            Decode: begin
                ctrl.abWrite = 1'b1;
                ctrl.aluOutWrite = 1'b1;
                nextCode = ExcInvalidOpcode;
                case (opcode)
                    OpRType: begin
                        case (funct)
                            FnAdd, FnAddu, FnSub, FnSubu, FnAnd, FnXor,
                            FnSll, FnSrl, FnSra: nextState = RCalc;
                            FnBreak: nextState = Halted;
                            default: nextState = ExcSave;
                        endcase
                    end
                    OpAddi, OpAddiu, OpSlti, OpAndi, OpXori: nextState = ICalc;
                    OpLw, OpSw: nextState = MemAddr;
                    OpBeq, OpBne: nextState = BranchEval;
                    OpJ: nextState = JumpExec;
                    OpLui: nextState = LuiWrite;
                    default: nextState = ExcSave;
                endcase
            end
            RCalc: begin
                ctrl.aluOutWrite = 1'b1;
                if (ctrl.overflow && (funct == FnAdd || funct == FnSub)) begin
                    nextCode = ExcOverflow;
                    nextState = ExcSave;
                end else begin
                    nextState = RWrite;
                end
            end
            ICalc: begin
                ctrl.aluOutWrite = 1'b1;
                if (ctrl.overflow && opcode == OpAddi) begin
                    nextCode = ExcOverflow;
                    nextState = ExcSave;
                end else begin
                    nextState = IWrite;
                end
            end
            RWrite, IWrite, LuiWrite, LoadWrite: ctrl.regWrite = 1'b1;
            MemAddr: begin
                ctrl.aluOutWrite = 1'b1;
                nextState = (opcode == OpLw) ? LoadRead : StoreWrite;
            end
            LoadRead: nextState = LoadWait; // address presented here
            LoadWait: begin
                ctrl.mdrWrite = 1'b1;
                nextState = LoadWrite;
            end
            StoreWrite: memWrite = 1'b1;
            BranchEval: ctrl.pcWrite = (opcode == OpBeq) ? ctrl.zero : !ctrl.zero;
            JumpExec: ctrl.pcWrite = 1'b1;
            ExcSave: begin
                ctrl.epcWrite = 1'b1;
                ctrl.causeWrite = 1'b1;
                nextState = ExcJump;
            end
            ExcJump: ctrl.pcWrite = 1'b1;
            Halted: nextState = Halted; // left only by reset
            default: nextState = Fetch;
        endcase
    end

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ps

module datapath #(
    parameter logic [mipsPkg::DataWidth-1:0] HandlerAddress = 32'h0000_0100
) (
    input logic clock,
    input logic reset,
    datapathCtrlIf.datapath ctrl,
    input logic [mipsPkg::DataWidth-1:0] memReadData,
    output logic [mipsPkg::DataWidth-1:0] memAddress,
    output logic [mipsPkg::DataWidth-1:0] memWriteData,
    output logic [mipsPkg::DataWidth-1:0] epc,
    output mipsPkg::excCauseT cause
);
    import mipsPkg::*;

    logic [DataWidth-1:0] pc;
    instrWordT ir;
    logic [DataWidth-1:0] aReg;
    logic [DataWidth-1:0] bReg;
    logic [DataWidth-1:0] aluOut;
    logic [DataWidth-1:0] mdr;
    logic [DataWidth-1:0] rfDataA;
    logic [DataWidth-1:0] rfDataB;
    logic [DataWidth-1:0] immSext;
    logic [DataWidth-1:0] immZext;
    logic [DataWidth-1:0] srcA;
    logic [DataWidth-1:0] srcB;
    logic [DataWidth-1:0] aluResult;
    logic [DataWidth-1:0] nextPc;
    logic [DataWidth-1:0] wbData;
    logic [RegAddrWidth-1:0] destReg;

    assign ctrl.instr = ir;
    assign memWriteData = bReg;
    assign memAddress = (ctrl.aluSrcA == SrcAPc) ? pc : aluOut; // fetch phase uses PC

    assign immSext = {{(DataWidth - 16){ir.iType.imm16[15]}}, ir.iType.imm16};
    assign immZext = {{(DataWidth - 16){1'b0}}, ir.iType.imm16};

    assign srcA = (ctrl.aluSrcA == SrcAPc) ? pc : aReg;

    always_comb begin
        case (ctrl.aluSrcB)
            SrcBReg: srcB = bReg;
            SrcBFour: srcB = DataWidth'(4);
            SrcBImm: begin
                // andi and xori take the zero-extended immediate
                if (ctrl.aluOp == AluAnd || ctrl.aluOp == AluXor)
                    srcB = immZext;
                else
                    srcB = immSext;
            end
            default: srcB = {immSext[DataWidth-3:0], 2'b00}; // word offset
        endcase
    end

    always_comb begin
        case (ctrl.pcSource)
            PcAluResult: nextPc = aluResult;
            PcAluOut: nextPc = aluOut;
            PcJump: nextPc = {pc[DataWidth-1:28], ir.jType.target26, 2'b00};
            default: nextPc = HandlerAddress;
        endcase
    end

    assign wbData = (ctrl.regSource == RegMdr) ? mdr : aluOut;
    assign destReg = ctrl.regDstRd ? ir.rType.rd : ir.rType.rt;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
            epc <= '0;
            cause <= ExcInvalidOpcode;
        end else begin
            if (ctrl.pcWrite)
                pc <= nextPc;
            if (ctrl.epcWrite)
                epc <= pc - DataWidth'(4); // pc already advanced past the fault
            if (ctrl.causeWrite)
                cause <= ctrl.excCode;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.irWrite)
            ir <= memReadData;
        if (ctrl.abWrite) begin
            aReg <= rfDataA;
            bReg <= rfDataB;
        end
        if (ctrl.aluOutWrite)
            aluOut <= aluResult;
        if (ctrl.mdrWrite)
            mdr <= memReadData;
    end

    registerFile regBank (
        .clock(clock),
        .reset(reset),
        .readAddrA(ir.rType.rs),
        .readAddrB(ir.rType.rt),
        .writeAddr(destReg),
        .writeData(wbData),
        .writeEnable(ctrl.regWrite),
        .readDataA(rfDataA),
        .readDataB(rfDataB)
    );

    alu aluUnit (
        .a(srcA),
        .b(srcB),
        .shamt(ir.rType.shamt),
        .op(ctrl.aluOp),
        .result(aluResult),
        .zero(ctrl.zero),
        .overflow(ctrl.overflow),
        .less(ctrl.less)
    );

endmodule

// ==== registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input logic clock,
    input logic reset,
    input logic [mipsPkg::RegAddrWidth-1:0] readAddrA,
    input logic [mipsPkg::RegAddrWidth-1:0] readAddrB,
    input logic [mipsPkg::RegAddrWidth-1:0] writeAddr,
    input logic [mipsPkg::DataWidth-1:0] writeData,
    input logic writeEnable,
    output logic [mipsPkg::DataWidth-1:0] readDataA,
    output logic [mipsPkg::DataWidth-1:0] readDataB
);
    import mipsPkg::*;

    logic [DataWidth-1:0] regs [2**RegAddrWidth];

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**RegAddrWidth; i++)
                regs[i] <= '0;
        end else if (writeEnable && writeAddr != '0) begin // $0 never written
            regs[writeAddr] <= writeData;
        end
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input logic [mipsPkg::DataWidth-1:0] a,
    input logic [mipsPkg::DataWidth-1:0] b,
    input logic [4:0] shamt,
    input mipsPkg::aluOpT op,
    output logic [mipsPkg::DataWidth-1:0] result,
    output logic zero,
    output logic overflow,
    output logic less
);
    import mipsPkg::*;

    localparam int Msb = DataWidth - 1;

    logic [DataWidth-1:0] sum;
    logic [DataWidth-1:0] diff;

    assign sum = a + b;
    assign diff = a - b;
    assign less = $signed(a) < $signed(b);
    assign zero = (result == '0);

    always_comb begin
        overflow = 1'b0;
        case (op)
            AluAdd: begin
                result = sum;
                overflow = (a[Msb] == b[Msb]) && (sum[Msb] != a[Msb]);
            end
            AluSub: begin
                result = diff;
                overflow = (a[Msb] != b[Msb]) && (diff[Msb] != a[Msb]);
            end
            AluAnd: result = a & b;
            AluXor: result = a ^ b;
            AluSlt: result = {{Msb{1'b0}}, less};
            AluSll: result = b << shamt;
            AluSrl: result = b >> shamt;
            AluSra: result = $signed(b) >>> shamt;
            AluLui: result = {b[15:0], 16'h0000};
            default: result = b; // pass B
        endcase
    end

endmodule

// ==== datapathCtrlIf.sv ====
`timescale 1ns/1ps

interface datapathCtrlIf;
    import mipsPkg::*;

    logic pcWrite;
    logic irWrite;
    logic regWrite;
    logic abWrite;
    logic aluOutWrite;
    logic mdrWrite;
    logic epcWrite;
    logic causeWrite;
    excCauseT excCode;
    logic regDstRd; // rd when high, rt otherwise
    aluSrcAT aluSrcA;
    aluSrcBT aluSrcB;
    aluOpT aluOp;
    pcSourceT pcSource;
    regSourceT regSource;

    instrWordT instr;
    logic zero;
    logic overflow;
    logic less;

    modport control (
        output pcWrite, irWrite, regWrite, abWrite, aluOutWrite, mdrWrite,
        output epcWrite, causeWrite, excCode, regDstRd,
        output aluSrcA, aluSrcB, aluOp, pcSource, regSource,
        input instr, zero, overflow, less
    );

    modport datapath (
        input pcWrite, irWrite, regWrite, abWrite, aluOutWrite, mdrWrite,
        input epcWrite, causeWrite, excCode, regDstRd,
        input aluSrcA, aluSrcB, aluOp, pcSource, regSource,
        output instr, zero, overflow, less
    );

endinterface

// ==== mipsPkg.sv ====
package mipsPkg;

    localparam int DataWidth = 32;
    localparam int RegAddrWidth = 5;

    typedef enum logic [5:0] {
        OpRType = 6'h00,
        OpJ     = 6'h02,
        OpBeq   = 6'h04,
        OpBne   = 6'h05,
        OpAddi  = 6'h08,
        OpAddiu = 6'h09,
        OpSlti  = 6'h0a,
        OpAndi  = 6'h0c,
        OpXori  = 6'h0e,
        OpLui   = 6'h0f,
        OpLw    = 6'h23,
        OpSw    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        FnSll   = 6'h00,
        FnSrl   = 6'h02,
        FnSra   = 6'h03,
        FnBreak = 6'h0d,
        FnAdd   = 6'h20,
        FnAddu  = 6'h21,
        FnSub   = 6'h22,
        FnSubu  = 6'h23,
        FnAnd   = 6'h24,
        FnXor   = 6'h26
    } functT;

    typedef enum logic [3:0] {
        AluPassB, AluAdd, AluSub, AluAnd, AluXor, AluSlt, AluSll, AluSrl, AluSra, AluLui
    } aluOpT;

    typedef enum logic {SrcAPc, SrcAReg} aluSrcAT;
    typedef enum logic [1:0] {SrcBReg, SrcBFour, SrcBImm, SrcBBranch} aluSrcBT;
    typedef enum logic [1:0] {PcAluResult, PcAluOut, PcJump, PcHandler} pcSourceT;
    typedef enum logic [1:0] {RegAluOut, RegMdr} regSourceT;
    typedef enum logic {ExcInvalidOpcode = 1'b0, ExcOverflow = 1'b1} excCauseT;

    typedef struct packed {
        opcodeT opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [RegAddrWidth-1:0] rd;
        logic [4:0] shamt;
        functT funct;
    } rTypeT;

    typedef struct packed {
        opcodeT opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [15:0] imm16;
    } iTypeT;

    typedef struct packed {
        opcodeT opcode;
        logic [25:0] target26;
    } jTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        jTypeT jType;
    } instrWordT;

endpackage
